// File: hw/calcPkg.sv
package calcPkg;

	// number format, sign in the top bit
	localparam int NumWidth = 21; // sign plus magnitude
	localparam int MagWidth = 20; // enough for 999999
	localparam int MaxMagnitude = 999999; // six decimal digits
	localparam int MaxFactorialArg = 9; // 10! no longer fits

	// display geometry
	localparam int DigitCount = 6;
	localparam int SegWidth = 7;
	localparam int DisplayWidth = DigitCount * SegWidth; // digit k at bits 7k+6..7k
	localparam int LedCount = 10;

	// opcodes, unary ones sit at the top
	localparam logic [3:0] OpAdd = 4'd0;
	localparam logic [3:0] OpSub = 4'd1;
	localparam logic [3:0] OpMul = 4'd2;
	localparam logic [3:0] OpDiv = 4'd3;
	localparam logic [3:0] OpFactorial = 4'd4;
	localparam int OpCount = 5;
	localparam logic [3:0] FirstUnaryOp = 4'd4; // factorial and above skip operand b

	// what the display is showing
	localparam logic [2:0] ModeReset = 3'd0;
	localparam logic [2:0] ModeEntry = 3'd1;
	localparam logic [2:0] ModeOperation = 3'd2;
	localparam logic [2:0] ModeAnswer = 3'd3;
	localparam logic [2:0] ModeError = 3'd4;

	// confirm sequence
	localparam logic [1:0] StepClear = 2'd0;
	localparam logic [1:0] StepFirst = 2'd1;
	localparam logic [1:0] StepOperation = 2'd2;
	localparam logic [1:0] StepSecond = 2'd3;

	// segment patterns, active low
	localparam logic [SegWidth-1:0] SegBlank = 7'b1111111;
	localparam logic [SegWidth-1:0] SegA = 7'b0001000; // capital A
	localparam logic [SegWidth-1:0] SegALow = 7'b0000010; // small a
	localparam logic [SegWidth-1:0] SegB = 7'b1100000;
	localparam logic [SegWidth-1:0] SegC = 7'b1110010;
	localparam logic [SegWidth-1:0] SegD = 7'b1000010;
	localparam logic [SegWidth-1:0] SegE = 7'b0110000;
	localparam logic [SegWidth-1:0] SegF = 7'b0111000;
	localparam logic [SegWidth-1:0] SegI = 7'b1111001;
	localparam logic [SegWidth-1:0] SegL = 7'b1001111;
	localparam logic [SegWidth-1:0] SegM = 7'b0001001; // half of an M, used twice
	localparam logic [SegWidth-1:0] SegO = 7'b0000001;
	localparam logic [SegWidth-1:0] SegR = 7'b0011001;
	localparam logic [SegWidth-1:0] SegS = 7'b0100100;
	localparam logic [SegWidth-1:0] SegT = 7'b1110000;
	localparam logic [SegWidth-1:0] SegU = 7'b1100011;
	localparam logic [SegWidth-1:0] SegV = 7'b1000001;

	// decimal digits, index is the digit value
	localparam logic [9:0][SegWidth-1:0] DigitSegments = {
		7'b0000100, // 9
		7'b0000000, // 8
		7'b0001111, // 7
		7'b0100000, // 6
		7'b0100100, // 5
		7'b1001100, // 4
		7'b0000110, // 3
		7'b0010010, // 2
		7'b1001111, // 1
		7'b0000001 // 0
	};

	// leftmost digit first in each word
	localparam logic [DisplayWidth-1:0] ResetWord = {SegR, SegE, SegS, SegE, SegT, SegBlank};
	localparam logic [DisplayWidth-1:0] ErrorWord = {SegE, SegR, SegR, SegO, SegR, SegBlank};

	localparam logic [OpCount-1:0][DisplayWidth-1:0] OpWords = {
		{SegF, SegALow, SegC, SegT, SegBlank, SegBlank}, // factorial
		{SegD, SegI, SegV, SegBlank, SegBlank, SegBlank}, // divide
		{SegM, SegM, SegU, SegL, SegT, SegBlank}, // multiply
		{SegS, SegU, SegB, SegBlank, SegBlank, SegBlank}, // subtract
		{SegA, SegD, SegD, SegBlank, SegBlank, SegBlank} // add
	};

endpackage

// File: hw/entryDecoder.sv
`timescale 1ns/10ps

module entryDecoder
(
	input logic CLOCK,
	input logic reset,
	input logic confirmStrobe,
	input logic stepStrobe,
	input logic [calcPkg::DigitCount-1:0] digitSelect, // bit k steps digit k
	input logic negativeSwitch,
	input logic resultStrobe,
	input logic [calcPkg::NumWidth-1:0] resultValue,
	input logic resultError,
	output logic executeStrobe,
	output logic [3:0] operation,
	output logic [calcPkg::NumWidth-1:0] operandA,
	output logic [calcPkg::NumWidth-1:0] operandB,
	output logic [calcPkg::DigitCount*4-1:0] entryDigits, // six bcd digits
	output logic entryNegative,
	output logic [2:0] displayMode
);

	logic [1:0] step; // where we are in the confirm sequence
	logic errorFlag; // sticky until reset
	logic answerChained; // operandA already holds the last answer
	logic [calcPkg::MagWidth-1:0] packedMag; // entry digits as binary
	logic [calcPkg::NumWidth-1:0] packedValue;
	logic strobeSeen;
	logic actAsConfirm;

	// bcd digits to binary, most significant first
	always_comb
	begin
		packedMag = '0;
		for (int k = calcPkg::DigitCount - 1; k >= 0; k--)
		begin
			packedMag = calcPkg::MagWidth'(packedMag * 10) // shift one decade
				+ calcPkg::MagWidth'(entryDigits[4*k +: 4]);
		end
	end

	// minus zero folds to plus zero
	assign packedValue = {entryNegative && (packedMag != '0), packedMag};

	assign strobeSeen = !errorFlag && (confirmStrobe || stepStrobe); // error blocks both
	assign actAsConfirm = confirmStrobe || (step == calcPkg::StepClear); // confirm wins

	always_ff @(posedge CLOCK)
	begin
		if (reset)
		begin
			step <= calcPkg::StepClear;
			errorFlag <= 1'b0;
			answerChained <= 1'b0;
			executeStrobe <= 1'b0;
			displayMode <= calcPkg::ModeReset;
		end
		else
		begin
			executeStrobe <= 1'b0; // one cycle only
			if (resultStrobe)
			begin
				if (resultError)
				begin
					errorFlag <= 1'b1;
					displayMode <= calcPkg::ModeError;
				end
				else
				begin
					operandA <= resultValue; // answer feeds the next round
					answerChained <= 1'b1;
					displayMode <= calcPkg::ModeAnswer;
				end
			end
			else if (strobeSeen && actAsConfirm)
			begin
				case (step)
					calcPkg::StepClear:
					begin
						entryDigits <= '0;
						entryNegative <= 1'b0;
						operation <= calcPkg::OpAdd;
						operandA <= '0;
						operandB <= '0;
						answerChained <= 1'b0;
						step <= calcPkg::StepFirst;
						displayMode <= calcPkg::ModeEntry; // six zeros
					end
					calcPkg::StepFirst:
					begin
						if (!answerChained)
							operandA <= packedValue; // else keep the answer
						entryDigits <= '0;
						entryNegative <= 1'b0;
						step <= calcPkg::StepOperation;
						displayMode <= calcPkg::ModeOperation;
					end
					calcPkg::StepOperation:
					begin
						if (operation >= calcPkg::FirstUnaryOp)
						begin
							executeStrobe <= 1'b1; // no second operand needed
							step <= calcPkg::StepFirst;
						end
						else
						begin
							step <= calcPkg::StepSecond;
							displayMode <= calcPkg::ModeEntry;
						end
					end
					default: // StepSecond
					begin
						operandB <= packedValue;
						entryDigits <= '0;
						entryNegative <= 1'b0;
						executeStrobe <= 1'b1;
						step <= calcPkg::StepFirst;
					end
				endcase
			end
			else if (strobeSeen)
			begin
				if (step == calcPkg::StepOperation)
				begin
					// cycle through the opcodes
					if (operation == 4'(calcPkg::OpCount - 1))
						operation <= calcPkg::OpAdd;
					else
						operation <= operation + 4'd1;
				end
				else
				begin
					for (int k = 0; k < calcPkg::DigitCount; k++)
					begin
						if (digitSelect[k])
							entryDigits[4*k +: 4] <= (entryDigits[4*k +: 4] == 4'd9) ? 4'd0
								: entryDigits[4*k +: 4] + 4'd1; // mod 10
					end
					entryNegative <= negativeSwitch;
					answerChained <= 1'b0; // user is typing a fresh number
					displayMode <= calcPkg::ModeEntry;
				end
			end
		end
	end

endmodule

// File: hw/arithUnit.sv
`timescale 1ns/10ps

module arithUnit
(
	input logic CLOCK,
	input logic reset,
	input logic executeStrobe,
	input logic [3:0] operation,
	input logic [calcPkg::NumWidth-1:0] operandA,
	input logic [calcPkg::NumWidth-1:0] operandB,
	output logic resultStrobe,
	output logic [calcPkg::NumWidth-1:0] resultValue,
	output logic resultError
);

	longint valueA; // signed views of the operands
	longint valueB;
	longint wideResult; // wide enough for the full product
	longint wideMag;
	logic badOperand; // zero divisor or bad factorial input
	logic overRange;

	// 0! through 9!
	function automatic longint factorialOf(input logic [3:0] n);
		case (n)
			4'd0: return 1;
			4'd1: return 1;
			4'd2: return 2;
			4'd3: return 6;
			4'd4: return 24;
			4'd5: return 120;
			4'd6: return 720;
			4'd7: return 5040;
			4'd8: return 40320;
			default: return 362880;
		endcase
	endfunction

	always_comb
	begin
		valueA = longint'(operandA[calcPkg::MagWidth-1:0]);
		if (operandA[calcPkg::NumWidth-1])
			valueA = -valueA;
		valueB = longint'(operandB[calcPkg::MagWidth-1:0]);
		if (operandB[calcPkg::NumWidth-1])
			valueB = -valueB;
		badOperand = 1'b0;
		wideResult = 0;
		case (operation)
			calcPkg::OpAdd: wideResult = valueA + valueB;
			calcPkg::OpSub: wideResult = valueA - valueB;
			calcPkg::OpMul: wideResult = valueA * valueB;
			calcPkg::OpDiv:
			begin
				if (valueB == 0)
					badOperand = 1'b1;
				else
					wideResult = valueA / valueB; // truncates toward zero
			end
			calcPkg::OpFactorial:
			begin
				if (operandA[calcPkg::NumWidth-1]
					|| operandA[calcPkg::MagWidth-1:0] > calcPkg::MaxFactorialArg)
					badOperand = 1'b1;
				else
					wideResult = factorialOf(operandA[3:0]); // operand b unused
			end
			default: badOperand = 1'b1; // unused opcodes
		endcase
		wideMag = (wideResult < 0) ? -wideResult : wideResult;
		overRange = wideMag > calcPkg::MaxMagnitude;
	end

	always_ff @(posedge CLOCK)
	begin
		if (reset)
			resultStrobe <= 1'b0;
		else
			resultStrobe <= executeStrobe; // one cycle latency
	end

	always_ff @(posedge CLOCK)
	begin
		if (executeStrobe)
		begin
			resultError <= badOperand || overRange;
			if (badOperand || overRange)
				resultValue <= '0;
			else
				resultValue <= {wideResult < 0, wideMag[calcPkg::MagWidth-1:0]}; // zero stays plus
		end
	end

endmodule

// File: hw/segmentDisplay.sv
`timescale 1ns/10ps

module segmentDisplay
(
	input logic CLOCK,
	input logic reset,
	input logic [2:0] displayMode,
	input logic [calcPkg::DigitCount*4-1:0] entryDigits,
	input logic entryNegative,
	input logic [3:0] operation,
	input logic resultStrobe,
	input logic [calcPkg::NumWidth-1:0] resultValue,
	output logic [calcPkg::DisplayWidth-1:0] displays, // active low
	output logic [calcPkg::LedCount-1:0] leds
);

	logic [calcPkg::NumWidth-1:0] answerValue; // last answer in sign-magnitude
	logic [calcPkg::DigitCount-1:0][3:0] answerDigits;
	logic [calcPkg::MagWidth-1:0] remaining; // divide-down scratch
	logic [calcPkg::DisplayWidth-1:0] entryWord;
	logic [calcPkg::DisplayWidth-1:0] answerWord;
	logic [calcPkg::DisplayWidth-1:0] operationWord;
	logic [calcPkg::DisplayWidth-1:0] nextDisplays;
	logic showNegative;

	// one bcd digit to its pattern
	function automatic logic [calcPkg::SegWidth-1:0] segOf(input logic [3:0] digit);
		if (digit > 4'd9)
			return calcPkg::SegBlank; // not a decimal digit
		return calcPkg::DigitSegments[digit];
	endfunction

	always_ff @(posedge CLOCK)
	begin
		if (resultStrobe)
			answerValue <= resultValue;
	end

	// answer magnitude split into decades from the units up
	always_comb
	begin
		remaining = answerValue[calcPkg::MagWidth-1:0];
		for (int k = 0; k < calcPkg::DigitCount; k++)
		begin
			answerDigits[k] = 4'(remaining % 10);
			remaining = calcPkg::MagWidth'(remaining / 10);
		end
	end

	always_comb
	begin
		for (int k = 0; k < calcPkg::DigitCount; k++)
		begin
			entryWord[calcPkg::SegWidth*k +: calcPkg::SegWidth] = segOf(entryDigits[4*k +: 4]);
			answerWord[calcPkg::SegWidth*k +: calcPkg::SegWidth] = segOf(answerDigits[k]);
		end
	end

	// mnemonic for the selected opcode
	assign operationWord = (operation < 4'(calcPkg::OpCount)) ? calcPkg::OpWords[operation]
		: {calcPkg::DigitCount{calcPkg::SegBlank}};

	always_comb
	begin
		case (displayMode)
			calcPkg::ModeEntry: nextDisplays = entryWord;
			calcPkg::ModeOperation: nextDisplays = operationWord;
			calcPkg::ModeAnswer: nextDisplays = answerWord;
			calcPkg::ModeError: nextDisplays = calcPkg::ErrorWord;
			default: nextDisplays = calcPkg::ResetWord;
		endcase
	end

	// sign leds follow whichever number is on show
	assign showNegative = (displayMode == calcPkg::ModeEntry && entryNegative)
		|| (displayMode == calcPkg::ModeAnswer && answerValue[calcPkg::NumWidth-1]);

	always_ff @(posedge CLOCK)
	begin
		if (reset)
		begin
			displays <= calcPkg::ResetWord;
			leds <= '0;
		end
		else
		begin
			displays <= nextDisplays;
			leds <= showNegative ? '1 : '0; // all or nothing
		end
	end

endmodule

// File: hw/calculator.sv
`timescale 1ns/10ps

module calculator
(
	input logic CLOCK,
	input logic reset,
	input logic confirmStrobe,
	input logic stepStrobe,
	input logic [calcPkg::DigitCount-1:0] digitSelect,
	input logic negativeSwitch,
	output logic [calcPkg::DisplayWidth-1:0] displays,
	output logic [calcPkg::LedCount-1:0] leds
);

	logic executeStrobe;
	logic [3:0] operation;
	logic [calcPkg::NumWidth-1:0] operandA;
	logic [calcPkg::NumWidth-1:0] operandB;
	logic [calcPkg::DigitCount*4-1:0] entryDigits;
	logic entryNegative;
	logic [2:0] displayMode;
	logic resultStrobe;
	logic [calcPkg::NumWidth-1:0] resultValue;
	logic resultError;

	// decode, step sequence and operands
	entryDecoder decoder
	(
		.CLOCK(CLOCK),
		.reset(reset),
		.confirmStrobe(confirmStrobe),
		.stepStrobe(stepStrobe),
		.digitSelect(digitSelect),
		.negativeSwitch(negativeSwitch),
		.resultStrobe(resultStrobe),
		.resultValue(resultValue),
		.resultError(resultError),
		.executeStrobe(executeStrobe),
		.operation(operation),
		.operandA(operandA),
		.operandB(operandB),
		.entryDigits(entryDigits),
		.entryNegative(entryNegative),
		.displayMode(displayMode)
	);

	// execute, one cycle
	arithUnit arith
	(
		.CLOCK(CLOCK),
		.reset(reset),
		.executeStrobe(executeStrobe),
		.operation(operation),
		.operandA(operandA),
		.operandB(operandB),
		.resultStrobe(resultStrobe),
		.resultValue(resultValue),
		.resultError(resultError)
	);

	segmentDisplay display
	(
		.CLOCK(CLOCK),
		.reset(reset),
		.displayMode(displayMode),
		.entryDigits(entryDigits),
		.entryNegative(entryNegative),
		.operation(operation),
		.resultStrobe(resultStrobe),
		.resultValue(resultValue),
		.displays(displays),
		.leds(leds)
	);

endmodule

// File: bench/clockGen.sv
`timescale 1ns/10ps

module clockGen
(
	input logic restart, // pulse to start a fresh reset
	output logic CLOCK,
	output logic reset
);

	localparam int Period = 8; // ns
	localparam int ResetCycles = 8;

	int resetCount = 0; // power-up starts inside reset

	initial
	begin
		CLOCK = 1'b0;
		forever
			#(Period / 2) CLOCK = ~CLOCK;
	end

	always @(posedge CLOCK)
	begin
		if (restart)
			resetCount <= 0;
		else if (resetCount < ResetCycles)
			resetCount <= resetCount + 1; // stops counting once released
	end

	assign reset = resetCount < ResetCycles; // high for eight edges

endmodule

// File: bench/calculatorTb.sv
`timescale 1ns/10ps

module calculatorTb;

	localparam int CycleLimit = 4000; // about twice the summed test length
	localparam int StrobeGap = 5; // idle cycles after every strobe

	logic CLOCK;
	logic reset;
	logic restart;
	logic confirmStrobe;
	logic stepStrobe;
	logic [calcPkg::DigitCount-1:0] digitSelect;
	logic negativeSwitch;
	logic [calcPkg::DisplayWidth-1:0] displays;
	logic [calcPkg::LedCount-1:0] leds;
	int cycleCount = 0;
	logic [31:0] rngState = 32'd96; // xorshift seed
	logic [3:0] currentOp; // opcode the DUT holds now

	clockGen clocks
	(
		.restart(restart),
		.CLOCK(CLOCK),
		.reset(reset)
	);

	calculator DUT
	(
		.CLOCK(CLOCK),
		.reset(reset),
		.confirmStrobe(confirmStrobe),
		.stepStrobe(stepStrobe),
		.digitSelect(digitSelect),
		.negativeSwitch(negativeSwitch),
		.displays(displays),
		.leds(leds)
	);

	always @(posedge CLOCK)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount > CycleLimit)
		begin
			$display("timeout: the tests did not finish within %0d cycles", CycleLimit);
			$display("TEST FAILED");
			$fatal(1, "cycle limit reached");
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int magnitudeOf(input int value);
		return (value < 0) ? -value : value;
	endfunction

	// six decimal digits, rightmost is the units
	function automatic logic [calcPkg::DisplayWidth-1:0] digitWord(input int magnitude);
		logic [calcPkg::DisplayWidth-1:0] word;
		int rest;
		rest = magnitude;
		for (int k = 0; k < calcPkg::DigitCount; k++)
		begin
			word[calcPkg::SegWidth*k +: calcPkg::SegWidth] = calcPkg::DigitSegments[rest % 10];
			rest = rest / 10;
		end
		return word;
	endfunction

	function automatic logic [calcPkg::LedCount-1:0] signLeds(input logic negative);
		return negative ? '1 : '0; // all or nothing
	endfunction

	function automatic logic [3:0] nextOp(input logic [3:0] op);
		return (op == 4'(calcPkg::OpCount - 1)) ? calcPkg::OpAdd : op + 4'd1;
	endfunction

	task automatic checkDisplays(input logic [calcPkg::DisplayWidth-1:0] expected);
		if (displays !== expected)
		begin
			$display("[FAIL] %0t ns displays expected %h got %h", $time, expected, displays);
			$display("TEST FAILED");
			$fatal(1, "displays mismatch");
		end
	endtask

	task automatic checkLeds(input logic [calcPkg::LedCount-1:0] expected);
		if (leds !== expected)
		begin
			$display("[FAIL] %0t ns leds expected %b got %b", $time, expected, leds);
			$display("TEST FAILED");
			$fatal(1, "leds mismatch");
		end
	endtask

	// drive point is 1 ns past the rising edge
	task automatic tick();
		@(posedge CLOCK);
		#1;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles)
			tick();
	endtask

	task automatic pressStep(input logic [calcPkg::DigitCount-1:0] mask, input logic negative);
		digitSelect = mask;
		negativeSwitch = negative;
		stepStrobe = 1'b1;
		tick();
		stepStrobe = 1'b0; // one cycle wide
		idle(StrobeGap);
	endtask

	task automatic confirm();
		confirmStrobe = 1'b1;
		tick();
		confirmStrobe = 1'b0;
		idle(StrobeGap);
	endtask

	task automatic resetDut();
		restart = 1'b1;
		tick();
		restart = 1'b0;
		while (reset)
			tick();
		tick(); // first edge out of reset
		checkDisplays(calcPkg::ResetWord);
		checkLeds('0);
	endtask

	task automatic clearEntry();
		confirm();
		currentOp = calcPkg::OpAdd; // clear picks add
		checkDisplays(digitWord(0));
		checkLeds('0);
	endtask

	// digits start at zero, each pass steps the digits still short of their value
	task automatic enterNumber(input int magnitude, input logic negative);
		int digits[calcPkg::DigitCount];
		int rest;
		logic [calcPkg::DigitCount-1:0] mask;
		logic stepped;
		rest = magnitude;
		stepped = 1'b0;
		for (int k = 0; k < calcPkg::DigitCount; k++)
		begin
			digits[k] = rest % 10;
			rest = rest / 10;
		end
		for (int pass = 1; pass <= 9; pass++)
		begin
			mask = '0;
			for (int k = 0; k < calcPkg::DigitCount; k++)
				mask[k] = digits[k] >= pass;
			if (mask != '0)
			begin
				pressStep(mask, negative);
				stepped = 1'b1;
			end
		end
		if (!stepped)
			pressStep('0, negative); // zero still latches the sign
		checkDisplays(digitWord(magnitude));
		checkLeds(signLeds(negative));
	endtask

	task automatic selectOp(input logic [3:0] op);
		while (currentOp != op)
		begin
			pressStep('0, 1'b0);
			currentOp = nextOp(currentOp);
			checkDisplays(calcPkg::OpWords[currentOp]);
		end
	endtask

	// expected result straight from the arithmetic rules
	task automatic predict(input logic [3:0] op, input longint a, input longint b,
		output longint answer, output logic error);
		longint magA;
		longint magB;
		magA = (a < 0) ? -a : a;
		magB = (b < 0) ? -b : b;
		error = 1'b0;
		answer = 0;
		case (op)
			calcPkg::OpAdd: answer = a + b;
			calcPkg::OpSub: answer = a - b;
			calcPkg::OpMul: answer = a * b;
			calcPkg::OpDiv:
			begin
				if (b == 0)
					error = 1'b1;
				else
				begin
					answer = magA / magB; // toward zero
					if ((a < 0) != (b < 0))
						answer = -answer;
				end
			end
			default:
			begin
				if (a < 0 || a > calcPkg::MaxFactorialArg)
					error = 1'b1;
				else
				begin
					answer = 1;
					for (longint n = 2; n <= a; n++)
						answer = answer * n;
				end
			end
		endcase
		if (answer > calcPkg::MaxMagnitude || answer < -calcPkg::MaxMagnitude)
			error = 1'b1;
	endtask

	task automatic checkOutcome(input longint answer, input logic error);
		if (error)
		begin
			checkDisplays(calcPkg::ErrorWord);
			checkLeds('0);
		end
		else
		begin
			checkDisplays(digitWord(int'((answer < 0) ? -answer : answer)));
			checkLeds(signLeds(answer < 0));
		end
	endtask

	// from the operation step to the shown answer
	task automatic finishOp(input int a, input logic [3:0] op, input int b, output int answer);
		longint expected;
		logic error;
		selectOp(op);
		confirm();
		if (op < calcPkg::FirstUnaryOp)
		begin
			checkDisplays(digitWord(0)); // second operand starts empty
			checkLeds('0);
			enterNumber(magnitudeOf(b), b < 0);
			confirm();
		end
		predict(op, a, b, expected, error);
		checkOutcome(expected, error);
		answer = error ? 0 : int'(expected);
	endtask

	// operand a already in the DUT, typed or chained
	task automatic applyOp(input int a, input logic [3:0] op, input int b, output int answer);
		confirm();
		checkDisplays(calcPkg::OpWords[currentOp]);
		finishOp(a, op, b, answer);
	endtask

	task automatic runBinary(input int a, input logic [3:0] op, input int b, output int answer);
		enterNumber(magnitudeOf(a), a < 0);
		applyOp(a, op, b, answer);
	endtask

	task automatic checkBlocked();
		pressStep('1, 1'b1);
		checkDisplays(calcPkg::ErrorWord);
		checkLeds('0);
		confirm();
		checkDisplays(calcPkg::ErrorWord);
		checkLeds('0);
	endtask

	task automatic testResetAndClear();
		resetDut();
		idle(3);
		checkDisplays(calcPkg::ResetWord); // holds without strobes
		clearEntry();
	endtask

	task automatic testEntryAndSign();
		int a;
		int b;
		int answer;
		resetDut();
		clearEntry();
		for (int i = 1; i <= 10; i++)
		begin
			pressStep('1, 1'b0);
			checkDisplays(digitWord(111111 * (i % 10))); // every digit, wraps at ten
		end
		pressStep('0, 1'b1);
		checkDisplays(digitWord(0));
		checkLeds('1);
		for (int i = 0; i < 4; i++)
		begin
			rngState = xorshift(rngState);
			a = int'(rngState % 32'd500000); // sums stay in range
			if (rngState[31])
				a = -a;
			rngState = xorshift(rngState);
			b = int'(rngState % 32'd500000);
			if (rngState[30])
				b = -b;
			runBinary(a, (i % 2 == 0) ? calcPkg::OpAdd : calcPkg::OpSub, b, answer);
		end
	endtask

	task automatic testOperations();
		int answer;
		resetDut();
		clearEntry();
		enterNumber(3, 1'b0);
		confirm();
		checkDisplays(calcPkg::OpWords[calcPkg::OpAdd]);
		for (int i = 0; i < calcPkg::OpCount; i++)
		begin
			pressStep('0, 1'b0);
			currentOp = nextOp(currentOp);
			checkDisplays(calcPkg::OpWords[currentOp]); // last one wraps to add
		end
		finishOp(3, calcPkg::OpMul, -7, answer);
		runBinary(-123, calcPkg::OpMul, 456, answer);
		runBinary(1000, calcPkg::OpDiv, -7, answer);
		runBinary(-5, calcPkg::OpDiv, 9, answer); // zero, shown positive
	endtask

	task automatic testChainAndFactorial();
		int answer;
		resetDut();
		clearEntry();
		runBinary(12, calcPkg::OpMul, 34, answer);
		applyOp(answer, calcPkg::OpSub, 500, answer);
		applyOp(answer, calcPkg::OpMul, -3, answer);
		enterNumber(7, 1'b0);
		applyOp(7, calcPkg::OpFactorial, 0, answer);
		applyOp(answer, calcPkg::OpDiv, 12, answer);
	endtask

	task automatic testErrors();
		int answer;
		resetDut();
		clearEntry();
		runBinary(1000, calcPkg::OpMul, 1000, answer); // product past six digits
		checkBlocked();
		resetDut();
		clearEntry();
		runBinary(5, calcPkg::OpDiv, 0, answer);
		checkBlocked();
		resetDut();
		clearEntry();
		enterNumber(10, 1'b0);
		applyOp(10, calcPkg::OpFactorial, 0, answer);
		checkBlocked();
	endtask

	initial
	begin
		restart = 1'b0;
		confirmStrobe = 1'b0;
		stepStrobe = 1'b0;
		digitSelect = '0;
		negativeSwitch = 1'b0;
		currentOp = calcPkg::OpAdd;
		tick();
		testResetAndClear();
		testEntryAndSign();
		testOperations();
		testChainAndFactorial();
		testErrors();
		$display("TEST OK");
		$finish;
	end

endmodule

// File: build.f
hw/calcPkg.sv
hw/entryDecoder.sv
hw/arithUnit.sv
hw/segmentDisplay.sv
hw/calculator.sv
bench/clockGen.sv
bench/calculatorTb.sv

// File: Makefile
TOP = calculatorTb

obj_dir/V$(TOP): build.f $(wildcard hw/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing -Wno-fatal -f build.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: run clean
